//--- list.f
design/cam_pkg.sv
design/pixel_fifo_if.sv
design/pixel_packer.sv
design/frame_fifo.sv
design/vga_pixel_driver.sv
design/frame_rate_meter.sv
design/camera_frame_path.sv
verif/camera_frame_path_sva.sv
verif/camera_frame_path_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the camera frame path testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module camera_frame_path_tb -o camera_frame_path_sim \
  > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed"
  exit 1
fi

./obj_dir/camera_frame_path_sim > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "FAIL: see errors above" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- verif/camera_frame_path_tb.sv
// ==============================
// Camera frame path testbench
// Table-driven pixel traffic, queue model and frame rate checks
// ==============================
module camera_frame_path_tb
  import cam_pkg::*;
();

  localparam int TBL_LEN   = 9;
  localparam int CYC_LIMIT = TBL_LEN * 40 + 4 * RATE_WINDOW;

  // One stimulus row
  typedef struct {
    pixel_format_e    fmt;
    logic             alt;      // Alternate hue and RGB per pixel
    logic [PIX_W-1:0] red;
    logic [PIX_W-1:0] green;
    logic [PIX_W-1:0] blue;
    logic [HUE_W-1:0] hue;
    logic [2:0]       chan;
    int               n_wr;     // Pixels written before reads
    int               n_rd;     // Display slots
    logic             exp_ovf;  // Sticky flags after the row
    logic             exp_udf;
  } row_t;

  logic               ccd_pixel_clk;
  logic               rst;
  pixel_format_e      format_sel;
  logic [PIX_W-1:0]   rgb_red;
  logic [PIX_W-1:0]   rgb_green;
  logic [PIX_W-1:0]   rgb_blue;
  logic               rgb_valid;
  logic [HUE_W-1:0]   hue;
  logic               hue_valid;
  logic               frame_valid;
  logic               disp_ena;
  logic [2:0]         chan_en;
  logic [VGA_W-1:0]   vga_r;
  logic [VGA_W-1:0]   vga_g;
  logic [VGA_W-1:0]   vga_b;
  logic               vga_valid;
  logic               overflow;
  logic               underflow;
  logic [RATE_W-1:0]  frame_rate;
  logic               window_toggle;

  row_t               tbl [TBL_LEN];
  fifo_word_t         model_q [$];   // FIFO contents model
  logic [3*VGA_W-1:0] exp_q [$];     // Expected {r, g, b} per display slot
  int                 cycles;
  int                 run_edges;     // Clock edges since reset release

  camera_frame_path u_camera_frame_path (.*);

  always #50 ccd_pixel_clk = ~ccd_pixel_clk;

  // ==============================
  // Failure reporting and compares
  // ==============================
  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_channel(input string name, input logic [VGA_W-1:0] got,
                               input logic [VGA_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rate(input string name, input logic [RATE_W-1:0] got,
                            input logic [RATE_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // ==============================
  // Reference packing rules
  // ==============================
  function automatic fifo_word_t pack_pixel(input pixel_format_e f, input logic [11:0] r,
                                            input logic [11:0] g, input logic [11:0] b,
                                            input logic [7:0] h);
    fifo_word_t w;
    if (f == FMT_HUE) w = {1'b1, 7'h00, h};                   // Gray byte, flag set
    else              w = {1'b0, r[11:7], g[11:7], b[11:7]};  // RGB555
    return w;
  endfunction

  function automatic logic [23:0] expect_pixel(input fifo_word_t w, input logic [2:0] ch);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    if (w[15]) begin
      r = w[7:0];                                  // Mask ignored for hue
      g = w[7:0];
      b = w[7:0];
    end else begin
      r = ch[2] ? {w[14:10], 3'b000} : 8'h00;
      g = ch[1] ? {w[9:5], 3'b000} : 8'h00;
      b = ch[0] ? {w[4:0], 3'b000} : 8'h00;
    end
    return {r, g, b};
  endfunction

  // Row with random colour values
  task automatic set_row(input int idx, input pixel_format_e f, input logic alt,
                         input logic [2:0] ch, input int nw, input int nr,
                         input logic ovf, input logic udf);
    tbl[idx].fmt     = f;
    tbl[idx].alt     = alt;
    tbl[idx].red     = PIX_W'($urandom);
    tbl[idx].green   = PIX_W'($urandom);
    tbl[idx].blue    = PIX_W'($urandom);
    tbl[idx].hue     = HUE_W'($urandom);
    tbl[idx].chan    = ch;
    tbl[idx].n_wr    = nw;
    tbl[idx].n_rd    = nr;
    tbl[idx].exp_ovf = ovf;
    tbl[idx].exp_udf = udf;
  endtask

  task automatic fill_table();
    set_row(0, FMT_RGB555, 1'b0, 3'b111,  4,  4, 1'b0, 1'b0);
    tbl[0].red   = 12'hfff;                       // Fixed first row
    tbl[0].green = 12'h0a5;
    tbl[0].blue  = 12'h800;
    set_row(1, FMT_RGB555, 1'b0, 3'b111,  5,  5, 1'b0, 1'b0);
    set_row(2, FMT_RGB555, 1'b0, 3'b100,  3,  3, 1'b0, 1'b0);  // Red only
    set_row(3, FMT_RGB555, 1'b0, 3'b010,  3,  3, 1'b0, 1'b0);  // Green only
    set_row(4, FMT_RGB555, 1'b0, 3'b001,  3,  3, 1'b0, 1'b0);  // Blue only
    set_row(5, FMT_HUE,    1'b0, 3'b010,  4,  4, 1'b0, 1'b0);
    set_row(6, FMT_HUE,    1'b1, 3'b001,  6,  6, 1'b0, 1'b0);  // Mixed formats
    set_row(7, FMT_RGB555, 1'b0, 3'b111, FIFO_DEPTH + 3, FIFO_DEPTH, 1'b1, 1'b0);
    set_row(8, FMT_RGB555, 1'b0, 3'b111,  0,  2, 1'b1, 1'b1);  // Reads on empty
  endtask

  // ==============================
  // Row and rate sequences
  // ==============================
  task automatic run_row(input row_t row);
    pixel_format_e    pf;
    logic [PIX_W-1:0] r;
    logic [PIX_W-1:0] g;
    logic [PIX_W-1:0] b;
    logic [HUE_W-1:0] h;
    @(posedge ccd_pixel_clk);
    chan_en <= row.chan;
    for (int i = 0; i < row.n_wr; i++) begin
      pf = (row.alt && (i % 2 == 1)) ? FMT_RGB555 : row.fmt;
      r  = row.red + PIX_W'(i * 309);
      g  = row.green + PIX_W'(i * 151);
      b  = row.blue + PIX_W'(i * 77);
      h  = row.hue + HUE_W'(i * 29);
      format_sel <= pf;
      rgb_red    <= r;
      rgb_green  <= g;
      rgb_blue   <= b;
      hue        <= h;
      rgb_valid  <= (pf == FMT_RGB555);
      hue_valid  <= (pf == FMT_HUE);
      if (model_q.size() < FIFO_DEPTH) model_q.push_back(pack_pixel(pf, r, g, b, h));
      @(posedge ccd_pixel_clk);
    end
    rgb_valid <= 1'b0;
    hue_valid <= 1'b0;
    repeat (3) @(posedge ccd_pixel_clk);          // Let queued writes land
    for (int j = 0; j < row.n_rd; j++) begin
      disp_ena <= 1'b1;
      if (model_q.size() == 0) exp_q.push_back('0);  // Miss gives black
      else exp_q.push_back(expect_pixel(model_q.pop_front(), row.chan));
      @(posedge ccd_pixel_clk);
    end
    disp_ena <= 1'b0;
    while (exp_q.size() != 0) @(negedge ccd_pixel_clk);
    repeat (2) @(negedge ccd_pixel_clk);
    check_flag("overflow", overflow, row.exp_ovf);
    check_flag("underflow", underflow, row.exp_udf);
  endtask

  task automatic wait_toggle();
    logic t;
    t = window_toggle;
    while (window_toggle === t) @(negedge ccd_pixel_clk);
  endtask

  // k frame starts inside one window, starting just after a window edge
  task automatic measure_rate(input int k);
    for (int i = 0; i < k; i++) begin
      @(posedge ccd_pixel_clk);
      frame_valid <= 1'b1;
      @(posedge ccd_pixel_clk);
      frame_valid <= 1'b0;
    end
    wait_toggle();
    check_rate("frame_rate", frame_rate, RATE_W'(k));
  endtask

  // ==============================
  // Output monitor and timeout
  // ==============================
  always @(negedge ccd_pixel_clk) begin : out_monitor
    logic [3*VGA_W-1:0] exp_rgb;
    if (!rst && vga_valid) begin
      if (exp_q.size() == 0) begin
        $display("vga_valid went high with no display slot requested");
        abort_run();
      end
      exp_rgb = exp_q.pop_front();
      check_channel("vga_r", vga_r, exp_rgb[23:16]);
      check_channel("vga_g", vga_g, exp_rgb[15:8]);
      check_channel("vga_b", vga_b, exp_rgb[7:0]);
    end
  end

  // Window phase reference, counted from the first edge out of reset
  always @(posedge ccd_pixel_clk) begin
    if (rst) begin
      run_edges <= 0;
    end else begin
      run_edges <= run_edges + 1;
    end
  end

  // Toggle flips once every RATE_WINDOW edges
  always @(negedge ccd_pixel_clk) begin
    if (!rst) begin
      check_flag("window_toggle", window_toggle, ((run_edges / RATE_WINDOW) % 2) == 1);
    end
  end

  always @(posedge ccd_pixel_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYC_LIMIT) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      abort_run();
    end
  end

  initial begin
    void'($urandom(32'h94f6));                    // Fixed seed
    ccd_pixel_clk = 1'b0;
    rst           = 1'b1;
    format_sel    = FMT_RGB555;
    rgb_red       = '0;
    rgb_green     = '0;
    rgb_blue      = '0;
    rgb_valid     = 1'b0;
    hue           = '0;
    hue_valid     = 1'b0;
    frame_valid   = 1'b0;
    disp_ena      = 1'b0;
    chan_en       = 3'b111;
    cycles        = 0;
    run_edges     = 0;
    fill_table();
    repeat (2) @(posedge ccd_pixel_clk);
    rst <= 1'b0;
    for (int r = 0; r < TBL_LEN; r++) run_row(tbl[r]);
    wait_toggle();                                // Align to a window start
    measure_rate(5);
    measure_rate(17);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- verif/camera_frame_path_sva.sv
// ==============================
// FIFO occupancy and display timing assertions
// ==============================
module camera_frame_path_sva
  import cam_pkg::*;
(
  input logic               ccd_pixel_clk,
  input logic               rst,
  input logic [FIFO_AW:0]   occ,        // FIFO occupancy
  input logic               rd_en,
  input logic               empty,
  input logic               disp_ena,
  input logic               vga_valid
);

  // Never more words than entries
  a_occ_limit: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    occ <= (FIFO_AW+1)'(FIFO_DEPTH))
    else $error("FIFO occupancy above depth");

  // Reader only pops a non-empty FIFO
  a_no_empty_read: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    rd_en |-> !empty)
    else $error("rd_en high while FIFO empty");

  // Request stage then output stage
  a_valid_follow: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    vga_valid == $past(disp_ena, 2))
    else $error("vga_valid out of step with disp_ena");

endmodule

bind frame_fifo camera_frame_path_sva u_fifo_sva (
  .ccd_pixel_clk (ccd_pixel_clk),
  .rst           (rst),
  .occ           (count),
  .rd_en         (buff.rd_en),
  .empty         (buff.empty),
  .disp_ena      (1'b0),
  .vga_valid     (1'b0)
);

bind vga_pixel_driver camera_frame_path_sva u_driver_sva (
  .ccd_pixel_clk (ccd_pixel_clk),
  .rst           (rst),
  .occ           ('0),
  .rd_en         (rd.rd_en),
  .empty         (rd.empty),
  .disp_ena      (disp_ena),
  .vga_valid     (vga_valid)
);

//--- design/camera_frame_path.sv
// ==============================
// Camera frame path top
// Packer, frame FIFO, VGA driver and frame rate meter
// ==============================
module camera_frame_path
  import cam_pkg::*;
(
  input  logic               ccd_pixel_clk,
  input  logic               rst,
  // Producer side
  input  pixel_format_e      format_sel,
  input  logic [PIX_W-1:0]   rgb_red,
  input  logic [PIX_W-1:0]   rgb_green,
  input  logic [PIX_W-1:0]   rgb_blue,
  input  logic               rgb_valid,
  input  logic [HUE_W-1:0]   hue,
  input  logic               hue_valid,
  input  logic               frame_valid,
  // Display side
  input  logic               disp_ena,
  input  logic [2:0]         chan_en,
  output logic [VGA_W-1:0]   vga_r,
  output logic [VGA_W-1:0]   vga_g,
  output logic [VGA_W-1:0]   vga_b,
  output logic               vga_valid,
  // Status
  output logic               overflow,
  output logic               underflow,
  output logic [RATE_W-1:0]  frame_rate,
  output logic               window_toggle
);

  pixel_fifo_if pix_bus ();   // Packer to FIFO to driver

  pixel_packer u_packer (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .format_sel    (format_sel),
    .rgb_red       (rgb_red),
    .rgb_green     (rgb_green),
    .rgb_blue      (rgb_blue),
    .rgb_valid     (rgb_valid),
    .hue           (hue),
    .hue_valid     (hue_valid),
    .wr            (pix_bus.packer)
  );

  frame_fifo u_fifo (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .buff          (pix_bus.buffer),
    .overflow      (overflow)
  );

  vga_pixel_driver u_driver (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .disp_ena      (disp_ena),
    .chan_en       (chan_en),
    .rd            (pix_bus.display),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b),
    .vga_valid     (vga_valid),
    .underflow     (underflow)
  );

  frame_rate_meter u_rate_meter (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .frame_valid   (frame_valid),
    .frame_rate    (frame_rate),
    .window_toggle (window_toggle)
  );

endmodule

//--- design/frame_rate_meter.sv
// ==============================
// Frame rate meter
// Counts frame-valid starts per RATE_WINDOW cycles
// ==============================
module frame_rate_meter
  import cam_pkg::*;
(
  input  logic               ccd_pixel_clk,
  input  logic               rst,
  input  logic               frame_valid,
  output logic [RATE_W-1:0]  frame_rate,     // Count of the last full window
  output logic               window_toggle   // Flips at each window end
);

  logic              fv_q;                   // Previous frame_valid
  logic              fv_rise;
  logic [WIN_W-1:0]  win_cnt;                // Cycle within window
  logic [RATE_W-1:0] edge_cnt;               // Starts seen so far
  logic              win_last;

  assign fv_rise  = frame_valid & ~fv_q;
  assign win_last = (win_cnt == WIN_W'(RATE_WINDOW-1));

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fv_q          <= 1'b0;
      win_cnt       <= '0;
      edge_cnt      <= '0;
      frame_rate    <= '0;
      window_toggle <= 1'b0;
    end else begin
      fv_q    <= frame_valid;
      win_cnt <= win_cnt + 1'b1;             // Wraps at RATE_WINDOW
      if (win_last) begin
        frame_rate    <= edge_cnt + RATE_W'(fv_rise);  // Last-cycle edge included
        edge_cnt      <= '0;
        window_toggle <= ~window_toggle;
      end else begin
        edge_cnt <= edge_cnt + RATE_W'(fv_rise);
      end
    end
  end

endmodule

//--- design/vga_pixel_driver.sv
// ==============================
// VGA pixel driver
// Reads frame words while display is active and unpacks to VGA channels
// ==============================
module vga_pixel_driver
  import cam_pkg::*;
(
  input  logic              ccd_pixel_clk,
  input  logic              rst,
  input  logic              disp_ena,    // Active video
  input  logic [2:0]        chan_en,     // [2] red, [1] green, [0] blue
  pixel_fifo_if.display     rd,
  output logic [VGA_W-1:0]  vga_r,
  output logic [VGA_W-1:0]  vga_g,
  output logic [VGA_W-1:0]  vga_b,
  output logic              vga_valid,
  output logic              underflow    // Sticky until reset
);

  logic              pend_q;             // Display slot requested last edge
  logic              miss_q;             // That slot found the FIFO empty
  pixel_format_e     word_fmt;
  logic [VGA_W-1:0]  r_next;
  logic [VGA_W-1:0]  g_next;
  logic [VGA_W-1:0]  b_next;

  assign rd.rd_en = disp_ena & ~rd.empty;
  assign word_fmt = pixel_format_e'(rd.rd_data[WORD_W-1]);  // Format rides in the word

  // Unpack by the word's own flag
  always_comb begin
    r_next = '0;
    g_next = '0;
    b_next = '0;
    if (pend_q && !miss_q) begin
      if (word_fmt == FMT_HUE) begin
        r_next = rd.rd_data[HUE_W-1:0];   // Gray on all channels
        g_next = rd.rd_data[HUE_W-1:0];
        b_next = rd.rd_data[HUE_W-1:0];
      end else begin
        // Field in the channel MSBs, zero fill below
        if (chan_en[2]) r_next = {rd.rd_data[3*COMP_W-1 -: COMP_W], {(VGA_W-COMP_W){1'b0}}};
        if (chan_en[1]) g_next = {rd.rd_data[2*COMP_W-1 -: COMP_W], {(VGA_W-COMP_W){1'b0}}};
        if (chan_en[0]) b_next = {rd.rd_data[COMP_W-1:0], {(VGA_W-COMP_W){1'b0}}};
      end
    end
  end

  // ==============================
  // Request stage, same edge as the FIFO read
  // ==============================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      pend_q <= 1'b0;
      miss_q <= 1'b0;
    end else begin
      pend_q <= disp_ena;
      miss_q <= disp_ena & rd.empty;     // Nothing to show
    end
  end

  // ==============================
  // Output stage
  // ==============================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      vga_valid <= 1'b0;
      underflow <= 1'b0;
      vga_r     <= '0;
      vga_g     <= '0;
      vga_b     <= '0;
    end else begin
      vga_valid <= pend_q;
      underflow <= underflow | miss_q;
      vga_r     <= r_next;
      vga_g     <= g_next;
      vga_b     <= b_next;
    end
  end

endmodule

//--- design/frame_fifo.sv
// ==============================
// Frame word FIFO
// Circular buffer with sticky overflow on dropped writes
// ==============================
module frame_fifo
  import cam_pkg::*;
(
  input  logic          ccd_pixel_clk,
  input  logic          rst,
  pixel_fifo_if.buffer  buff,
  output logic          overflow      // Sticky until reset
);

  fifo_word_t          mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]  wr_ptr;
  logic [FIFO_AW-1:0]  rd_ptr;
  logic [FIFO_AW:0]    count;         // Occupancy, 0 to FIFO_DEPTH
  logic                full;
  logic                wr_ok;         // Accepted write

  assign full       = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign buff.empty = (count == '0);
  assign wr_ok      = buff.wr_en & ~full;

  // ==============================
  // Pointers and occupancy
  // ==============================
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;      // Wraps at FIFO_DEPTH
      end
      if (buff.rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;      // Reader guarantees not empty
      end
      case ({wr_ok, buff.rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // Idle or read+write
      endcase
      if (buff.wr_en && full) begin
        overflow <= 1'b1;             // Word dropped
      end
    end
  end

  // ==============================
  // Storage and read data
  // ==============================
  always_ff @(posedge ccd_pixel_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= buff.wr_data;
    end
  end

  // Holds until the next read
  always_ff @(posedge ccd_pixel_clk) begin
    if (buff.rd_en) begin
      buff.rd_data <= mem[rd_ptr];
    end
  end

endmodule

//--- design/pixel_packer.sv
// ==============================
// Pixel packer
// Builds RGB555 or hue frame words and writes them to the FIFO
// ==============================
module pixel_packer
  import cam_pkg::*;
(
  input  logic               ccd_pixel_clk,
  input  logic               rst,
  input  pixel_format_e      format_sel,   // Producer format switch
  input  logic [PIX_W-1:0]   rgb_red,
  input  logic [PIX_W-1:0]   rgb_green,
  input  logic [PIX_W-1:0]   rgb_blue,
  input  logic               rgb_valid,
  input  logic [HUE_W-1:0]   hue,
  input  logic               hue_valid,
  pixel_fifo_if.packer       wr
);

  fifo_word_t next_word;
  logic       next_wr;

  // Word select by current format
  always_comb begin
    if (format_sel == FMT_HUE) begin
      next_word = {FMT_HUE, {(WORD_W-1-HUE_W){1'b0}}, hue};  // Gray byte, flag set
      next_wr   = hue_valid;
    end else begin
      next_word = {FMT_RGB555,                    // Flag clear
                   rgb_red[PIX_W-1 -: COMP_W],    // Top 5 bits only
                   rgb_green[PIX_W-1 -: COMP_W],
                   rgb_blue[PIX_W-1 -: COMP_W]};
      next_wr   = rgb_valid;
    end
  end

  // Write strobe, one cycle behind the source strobe
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      wr.wr_en <= 1'b0;
    end else begin
      wr.wr_en <= next_wr;
    end
  end

  // Payload register
  always_ff @(posedge ccd_pixel_clk) begin
    wr.wr_data <= next_word;
  end

endmodule

//--- design/pixel_fifo_if.sv
// ==============================
// Frame word bus between packer, FIFO and display driver
// ==============================
interface pixel_fifo_if
  import cam_pkg::*;
();

  // Write side
  fifo_word_t wr_data;   // Packed word from the packer
  logic       wr_en;     // One word per cycle, never stalled

  // Read side
  logic       rd_en;     // Only raised when not empty
  fifo_word_t rd_data;   // Word read at the last rd_en edge
  logic       empty;

  modport packer (
    output wr_data, wr_en
  );

  modport buffer (
    input  wr_data, wr_en, rd_en,
    output rd_data, empty
  );

  modport display (
    output rd_en,
    input  rd_data, empty
  );

endinterface

//--- design/cam_pkg.sv
// ==============================
// Camera frame path definitions
// Widths, depths, frame word and pixel formats
// ==============================
package cam_pkg;

  // ==============================
  // Pixel and channel widths
  // ==============================
  localparam int PIX_W  = 12;          // Demosaiced RGB component
  localparam int COMP_W = 5;           // Packed bits per colour, upper bits kept
  localparam int HUE_W  = 8;           // Hue byte
  localparam int VGA_W  = 8;           // VGA colour channel
  localparam int WORD_W = 16;          // Frame word

  // ==============================
  // Buffer and rate window
  // ==============================
  localparam int FIFO_DEPTH  = 16;     // Stand-in for the SDRAM frame buffer
  localparam int FIFO_AW     = 4;      // log2 of FIFO_DEPTH
  localparam int RATE_WINDOW = 64;     // Cycles per measurement window
  localparam int RATE_W      = 16;     // Frame count width
  localparam int WIN_W       = $clog2(RATE_WINDOW); // Window cycle counter

  // Frame word layout
  // [15]     format flag
  // RGB555   [14:10] red, [9:5] green, [4:0] blue
  // Hue      [14:8] zero, [7:0] hue
  typedef logic [WORD_W-1:0] fifo_word_t;

  // Also the value carried in the flag bit
  typedef enum logic {
    FMT_RGB555 = 1'b0,
    FMT_HUE    = 1'b1
  } pixel_format_e;

endpackage
